// ==== build.f ====
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/ifetch.sv
verilog/idecode.sv
verilog/execute.sv
verilog/mem.sv
verilog/cpu_core.sv
verification/core_checker.sv
verification/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timescale 1ns/1ps --top-module core_tb -f build.f
out=$(./obj_dir/Vcore_tb)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Test OK"; then
   echo "simulation passed"
   exit 0
fi
echo "simulation failed"
exit 1

// ==== verification/core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_checker #(
   parameter cpu_isa_pkg::word_t result_adr_p = 32'h0000_0100,
   parameter cpu_isa_pkg::word_t check_adr_p  = 32'h0000_0104
) (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic [63:0]        name_i,
   input  cpu_isa_pkg::word_t expected_i,
   input  logic               ins_cyc_i,
   input  logic               ins_we_i,
   input  cpu_isa_pkg::word_t ins_adr_i,
   input  logic               dat_cyc_i,
   input  logic               dat_we_i,
   input  logic               dat_ack_i,
   input  cpu_isa_pkg::word_t dat_adr_i,
   input  cpu_isa_pkg::word_t dat_wdat_i,
   input  logic               halt_i,
   output logic               done_o,
   output int                 pass_count_o,
   output int                 fail_count_o
);

   import cpu_isa_pkg::*;

   logic  reset_q = 1'b0;
   logic  done_q = 1'b0;
   logic  ins_cyc_q;
   logic  reset_bad;
   logic  first_fetch;
   logic  first_adr_bad;
   logic  late_fetch;
   logic  ins_we_bad;
   int    idle_cycles;
   int    n_stores;
   word_t adr0;
   word_t dat0;
   word_t adr1;
   word_t dat1;
   int    n_pass = 0;
   int    n_fail = 0;

   task automatic report_test();
      logic ok;
      ok = 1'b0;
      if (reset_bad) begin
         $display("FAIL %s: a bus cycle or halt was active during reset", name_i);
      end else if (ins_we_bad) begin
         $display("FAIL %s: the instruction bus signalled a write", name_i);
      end else if (first_adr_bad) begin
         $display("FAIL %s: the first instruction fetch was not at the reset address", name_i);
      end else if (n_stores != 2) begin
         $display("FAIL %s: %0d stores completed before halt instead of 2", name_i, n_stores);
      end else if (adr0 != result_adr_p || adr1 != check_adr_p) begin
         $display("FAIL %s: stores went to addresses %h and %h", name_i, adr0, adr1);
      end else if (late_fetch) begin
         $display("FAIL %s: an instruction cycle started after halt", name_i);
      end else if (dat0 != expected_i) begin
         $display("[ERROR] %s expected %h actual %h", name_i, expected_i, dat0);
      end else if (dat1 != '0) begin
         $display("[ERROR] %s readback expected %h actual %h", name_i, 32'h0, dat1);
      end else begin
         ok = 1'b1;
      end
      if (ok) begin
         $display("PASS %s result %h", name_i, dat0);
         n_pass++;
      end else begin
         n_fail++;
      end
   endtask

   always @(posedge clk_i) begin
      reset_q   <= reset_i;
      ins_cyc_q <= ins_cyc_i;
      if (reset_i && !reset_q) begin
         done_q        <= 1'b0;
         reset_bad     <= 1'b0;
         first_fetch   <= 1'b1;
         first_adr_bad <= 1'b0;
         late_fetch    <= 1'b0;
         ins_we_bad    <= 1'b0;
         idle_cycles   <= 0;
         n_stores      <= 0;
      end else if (reset_i) begin
         // the first reset edge has cleared the core, so both buses must be idle
         if (ins_cyc_i || dat_cyc_i || halt_i) begin
            reset_bad <= 1'b1;
         end
      end else if (!done_q) begin
         if (first_fetch && ins_cyc_i) begin
            first_fetch   <= 1'b0;
            first_adr_bad <= ins_adr_i != 32'h0000_0000;
         end
         if (ins_we_i) begin
            ins_we_bad <= 1'b1;
         end
         if (halt_i && ins_cyc_i && !ins_cyc_q) begin
            late_fetch <= 1'b1;
         end
         // only stores that finish while halt is still low count
         if (dat_cyc_i && dat_we_i && dat_ack_i && !halt_i) begin
            if (n_stores == 0) begin
               adr0 <= dat_adr_i;
               dat0 <= dat_wdat_i;
            end else if (n_stores == 1) begin
               adr1 <= dat_adr_i;
               dat1 <= dat_wdat_i;
            end
            n_stores <= n_stores + 1;
         end
         // a running fetch reopens its cycle one cycle after each ack,
         // so four idle cycles under halt mean fetch has really stopped
         if (halt_i && !ins_cyc_i) begin
            idle_cycles <= idle_cycles + 1;
         end else begin
            idle_cycles <= 0;
         end
         if (late_fetch || idle_cycles == 4) begin
            done_q <= 1'b1;
            report_test();
         end
      end
   end

   assign done_o       = done_q;
   assign pass_count_o = n_pass;
   assign fail_count_o = n_fail;

endmodule

`default_nettype wire

// ==== verification/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;

   import cpu_isa_pkg::*;

   typedef struct packed {
      logic [63:0] name;
      opcode_e     op;
      logic [15:0] a;
      logic [15:0] b;
      word_t       expected;
   } row_t;

   localparam int    num_rows_c   = 8;
   localparam int    timeout_c    = 200 * num_rows_c;
   localparam word_t result_adr_c = 32'h0000_0100;
   localparam word_t check_adr_c  = 32'h0000_0104;

   // operands enter through LDI, so every expected value includes the sign extension
   localparam row_t rows_c [num_rows_c] = '{
      '{"add_base", op_add, 16'h1234, 16'h0042, 32'h0000_1276},
      '{"add_over", op_add, 16'h7fff, 16'h7fff, 32'h0000_fffe},
      '{"sub_borr", op_sub, 16'h0005, 16'h0007, 32'hffff_fffe},
      '{"sub_both", op_sub, 16'hffff, 16'h8000, 32'h0000_7fff},
      '{"and_mask", op_and, 16'h8f0f, 16'h7ff0, 32'h0000_0f00},
      '{"or_upper", op_or,  16'h8000, 16'h0001, 32'hffff_8001},
      '{"xor_full", op_xor, 16'h00ff, 16'hff00, 32'hffff_ffff},
      '{"ldi_sext", op_ldi, 16'ha5a5, 16'h0000, 32'hffff_a5a5}
   };

   logic        clk = 1'b0;
   logic        reset = 1'b1;
   logic        ins_ack = 1'b0;
   word_t       ins_dat = '0;
   logic        dat_ack = 1'b0;
   word_t       dat_rdat = '0;
   logic        ins_cyc;
   logic        ins_we;
   logic        dat_cyc;
   logic        dat_we;
   logic        halt;
   word_t       ins_adr;
   word_t       dat_adr;
   word_t       dat_wdat;
   word_t       imem [16];
   word_t       dmem [256];
   logic [1:0]  ins_wait = 2'd0;
   logic [1:0]  dat_wait = 2'd0;
   logic [31:0] rnd = 32'h97c;
   int          cycles = 0;
   logic        done;
   int          n_pass;
   int          n_fail;
   logic [63:0] cur_name = '0;
   word_t       cur_expected = '0;
   logic        timed_out = 1'b0;

   function automatic logic [31:0] lcg_next(logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic word_t encode(opcode_e op, reg_idx_t rd, reg_idx_t ra, logic [15:0] low);
      word_t w;
      w = '0;
      w[op_lsb_c +: 8] = op;
      w[rd_lsb_c +: $bits(reg_idx_t)] = rd;
      w[ra_lsb_c +: $bits(reg_idx_t)] = ra;
      w[imm_lsb_c +: imm_bits_c] = low;
      return w;
   endfunction

   // r3 gets the result, r5 gets the read back value xor r3
   task automatic load_program(row_t row);
      for (int i = 0; i < 16; i++) begin
         imem[i] = encode(op_nop, 4'd0, 4'd0, 16'd0);
      end
      imem[0] = encode(op_ldi, 4'd1, 4'd0, row.a);
      imem[1] = encode(op_ldi, 4'd2, 4'd0, row.b);
      if (row.op == op_ldi) begin
         imem[2] = encode(op_ldi, 4'd3, 4'd0, row.a);
      end else begin
         imem[2] = encode(row.op, 4'd3, 4'd1, 16'd2);
      end
      imem[3] = encode(op_st, 4'd3, 4'd0, result_adr_c[15:0]);
      imem[4] = encode(op_ld, 4'd4, 4'd0, result_adr_c[15:0]);
      imem[5] = encode(op_xor, 4'd5, 4'd4, 16'd3);
      imem[6] = encode(op_st, 4'd5, 4'd0, check_adr_c[15:0]);
      imem[7] = encode(op_halt, 4'd0, 4'd0, 16'd0);
      cur_name     = row.name;
      cur_expected = row.expected;
   endtask

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
   end

   // ------------------------------
   // bus memory models
   // ------------------------------
   always @(posedge clk) begin
      ins_ack <= 1'b0;
      dat_ack <= 1'b0;
      if (reset) begin
         ins_wait <= 2'd0;
         dat_wait <= 2'd0;
         for (int i = 0; i < 256; i++) begin
            dmem[i] <= {16'hd47a, 6'd0, i[7:0], 2'b00};
         end
      end else begin
         if (ins_cyc && !ins_ack) begin
            if (ins_wait == 2'd0) begin
               ins_ack  <= 1'b1;
               ins_dat  <= imem[ins_adr[5:2]];
               rnd = lcg_next(rnd);
               ins_wait <= rnd[17:16];
            end else begin
               ins_wait <= ins_wait - 2'd1;
            end
         end
         if (dat_cyc && !dat_ack) begin
            if (dat_wait == 2'd0) begin
               dat_ack <= 1'b1;
               if (dat_we) begin
                  dmem[dat_adr[9:2]] <= dat_wdat;
               end else begin
                  dat_rdat <= dmem[dat_adr[9:2]];
               end
               rnd = lcg_next(rnd);
               dat_wait <= rnd[17:16];
            end else begin
               dat_wait <= dat_wait - 2'd1;
            end
         end
      end
   end

   cpu_core i_dut (
      .clk_i(clk), .reset_i(reset),
      .ins_ack_i(ins_ack), .ins_dat_i(ins_dat), .ins_cyc_o(ins_cyc), .ins_we_o(ins_we),
      .ins_adr_o(ins_adr),
      .dat_ack_i(dat_ack), .dat_dat_i(dat_rdat), .dat_cyc_o(dat_cyc), .dat_we_o(dat_we),
      .dat_adr_o(dat_adr), .dat_dat_o(dat_wdat), .halt_o(halt)
   );

   core_checker #(.result_adr_p(result_adr_c), .check_adr_p(check_adr_c)) i_chk (
      .clk_i(clk), .reset_i(reset), .name_i(cur_name), .expected_i(cur_expected),
      .ins_cyc_i(ins_cyc), .ins_we_i(ins_we), .ins_adr_i(ins_adr),
      .dat_cyc_i(dat_cyc), .dat_we_i(dat_we),
      .dat_ack_i(dat_ack), .dat_adr_i(dat_adr), .dat_wdat_i(dat_wdat), .halt_i(halt),
      .done_o(done), .pass_count_o(n_pass), .fail_count_o(n_fail)
   );

   // ------------------------------
   // test sequence
   // ------------------------------
   initial begin
      for (int t = 0; t < num_rows_c && !timed_out; t++) begin
         load_program(rows_c[t]);
         @(posedge clk);
         reset <= 1'b1;
         repeat (16) @(posedge clk);
         reset <= 1'b0;
         @(negedge clk);
         while (!done && cycles < timeout_c) begin
            @(negedge clk);
         end
         if (!done) begin
            timed_out = 1'b1;
            $display("FAIL %s: halt was not reached within %0d cycles", cur_name, timeout_c);
         end
      end
      $display("summary: %0d passed, %0d failed", n_pass, n_fail + (timed_out ? 1 : 0));
      if (!timed_out && n_fail == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               ins_ack_i,
   input  cpu_isa_pkg::word_t ins_dat_i,
   output logic               ins_cyc_o,
   output logic               ins_we_o,
   output cpu_isa_pkg::word_t ins_adr_o,
   input  logic               dat_ack_i,
   input  cpu_isa_pkg::word_t dat_dat_i,
   output logic               dat_cyc_o,
   output logic               dat_we_o,
   output cpu_isa_pkg::word_t dat_adr_o,
   output cpu_isa_pkg::word_t dat_dat_o,
   output logic               halt_o
);

   import cpu_pipe_pkg::*;

   fetch_pkt_t fetch;
   exec_pkt_t  exec;
   mem_pkt_t   mem_pkt;
   wb_pkt_t    wb;
   logic       decode_ready;
   logic       fetch_stop;
   logic       mem_ready;

   // the instruction bus only ever reads
   assign ins_we_o = 1'b0;

   ifetch i_fetch (
      .clk_i, .reset_i, .ins_ack_i, .ins_dat_i, .ins_cyc_o, .ins_adr_o,
      .decode_ready_i(decode_ready), .fetch_stop_i(fetch_stop), .fetch_o(fetch)
   );

   idecode i_decode (
      .clk_i, .reset_i, .fetch_i(fetch), .decode_ready_o(decode_ready),
      .fetch_stop_o(fetch_stop), .exec_o(exec), .exec_busy_i(exec),
      .mem_i(mem_pkt), .wb_i(wb), .mem_ready_i(mem_ready)
   );

   execute i_exec (
      .clk_i, .reset_i, .exec_i(exec), .mem_ready_i(mem_ready), .mem_o(mem_pkt)
   );

   mem i_mem (
      .clk_i, .reset_i, .mem_i(mem_pkt), .mem_ready_o(mem_ready),
      .dat_ack_i, .dat_dat_i, .dat_cyc_o, .dat_we_o, .dat_adr_o, .dat_dat_o,
      .wb_o(wb), .halt_o
   );

endmodule

`default_nettype wire

// ==== verilog/cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

   localparam int num_regs_c = 16;

   typedef logic [31:0] word_t;
   typedef logic [$clog2(num_regs_c)-1:0] reg_idx_t;

   // the opcode lives in the top byte of every instruction word
   typedef enum logic [7:0] {
      op_nop  = 8'h00,
      op_add  = 8'h10,
      op_sub  = 8'h11,
      op_and  = 8'h12,
      op_or   = 8'h13,
      op_xor  = 8'h14,
      op_ldi  = 8'h20,
      op_ld   = 8'h30,
      op_st   = 8'h31,
      op_halt = 8'hff
   } opcode_e;

   // ------------------------------
   // instruction field positions
   // ------------------------------
   // ST takes its store data from the rd field, since rb overlaps the immediate
   localparam int op_lsb_c   = 24;
   localparam int rd_lsb_c   = 20;
   localparam int ra_lsb_c   = 16;
   localparam int rb_lsb_c   = 0;
   localparam int imm_lsb_c  = 0;
   localparam int imm_bits_c = 16;

   localparam word_t reset_pc_c = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== verilog/cpu_pipe_pkg.sv ====
`default_nettype none

package cpu_pipe_pkg;

   // fetch register, ifetch to idecode
   typedef struct packed {
      logic               valid;
      cpu_isa_pkg::word_t pc;
      cpu_isa_pkg::word_t ins;
   } fetch_pkt_t;

   // operands are already read from the register file here
   typedef struct packed {
      logic                  valid;
      cpu_isa_pkg::opcode_e  op;
      cpu_isa_pkg::reg_idx_t rd;
      cpu_isa_pkg::word_t    a;
      cpu_isa_pkg::word_t    b;
      cpu_isa_pkg::word_t    imm;
      logic                  writes_reg;
   } exec_pkt_t;

   // result holds the address for LD and ST
   typedef struct packed {
      logic                  valid;
      cpu_isa_pkg::opcode_e  op;
      cpu_isa_pkg::reg_idx_t rd;
      cpu_isa_pkg::word_t    result;
      cpu_isa_pkg::word_t    store_data;
      logic                  writes_reg;
   } mem_pkt_t;

   typedef struct packed {
      logic                  valid;
      cpu_isa_pkg::reg_idx_t rd;
      cpu_isa_pkg::word_t    data;
   } wb_pkt_t;

endpackage

`default_nettype wire

// ==== verilog/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute (
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  cpu_pipe_pkg::exec_pkt_t exec_i,
   input  logic                    mem_ready_i,
   output cpu_pipe_pkg::mem_pkt_t  mem_o
);

   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   mem_pkt_t mem_q;
   word_t    result;

   always_comb begin
      case (exec_i.op)
         op_add:       result = exec_i.a + exec_i.b;
         op_sub:       result = exec_i.a - exec_i.b;
         op_and:       result = exec_i.a & exec_i.b;
         op_or:        result = exec_i.a | exec_i.b;
         op_xor:       result = exec_i.a ^ exec_i.b;
         op_ldi:       result = exec_i.imm;
         // effective address for the data bus
         op_ld, op_st: result = exec_i.a + exec_i.imm;
         default:      result = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         mem_q.valid <= 1'b0;
      end else if (mem_ready_i) begin
         mem_q.valid      <= exec_i.valid;
         mem_q.op         <= exec_i.op;
         mem_q.rd         <= exec_i.rd;
         mem_q.result     <= result;
         mem_q.store_data <= exec_i.b;
         mem_q.writes_reg <= exec_i.writes_reg;
      end
   end

   assign mem_o = mem_q;

endmodule

`default_nettype wire

// ==== verilog/idecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module idecode (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  cpu_pipe_pkg::fetch_pkt_t fetch_i,
   output logic                     decode_ready_o,
   output logic                     fetch_stop_o,
   output cpu_pipe_pkg::exec_pkt_t  exec_o,
   input  cpu_pipe_pkg::exec_pkt_t  exec_busy_i,
   input  cpu_pipe_pkg::mem_pkt_t   mem_i,
   input  cpu_pipe_pkg::wb_pkt_t    wb_i,
   input  logic                     mem_ready_i
);

   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   word_t     regs [num_regs_c];
   exec_pkt_t exec_q;
   logic      halted_q;

   opcode_e   op;
   reg_idx_t  rd;
   reg_idx_t  ra;
   reg_idx_t  rb;
   word_t     imm;
   logic      use_ra;
   logic      use_rb;
   logic      use_rd;
   logic      writes;
   logic      hazard;
   logic      issue;

   // a source is busy while any later stage still has to write it
   function automatic logic pending(reg_idx_t r);
      logic in_exec;
      logic in_mem;
      logic in_wb;
      in_exec = exec_busy_i.valid && exec_busy_i.writes_reg && exec_busy_i.rd == r;
      in_mem  = mem_i.valid && mem_i.writes_reg && mem_i.rd == r;
      in_wb   = wb_i.valid && wb_i.rd == r;
      return (r != '0) && (in_exec || in_mem || in_wb);
   endfunction

   function automatic word_t read_reg(reg_idx_t r);
      return (r == '0) ? '0 : regs[r];
   endfunction

   // ------------------------------
   // field decode
   // ------------------------------
   assign op  = opcode_e'(fetch_i.ins[op_lsb_c +: 8]);
   assign rd  = fetch_i.ins[rd_lsb_c +: $bits(reg_idx_t)];
   assign ra  = fetch_i.ins[ra_lsb_c +: $bits(reg_idx_t)];
   assign rb  = fetch_i.ins[rb_lsb_c +: $bits(reg_idx_t)];
   assign imm = {{(32 - imm_bits_c){fetch_i.ins[imm_lsb_c + imm_bits_c - 1]}},
                 fetch_i.ins[imm_lsb_c +: imm_bits_c]};

   always_comb begin
      use_ra = 1'b0;
      use_rb = 1'b0;
      use_rd = 1'b0;
      writes = 1'b0;
      case (op)
         op_add, op_sub, op_and, op_or, op_xor: begin
            use_ra = 1'b1;
            use_rb = 1'b1;
            writes = 1'b1;
         end
         op_ldi: writes = 1'b1;
         op_ld: begin
            use_ra = 1'b1;
            writes = 1'b1;
         end
         op_st: begin
            use_ra = 1'b1;
            use_rd = 1'b1;
         end
         default: writes = 1'b0;
      endcase
   end

   assign hazard = fetch_i.valid && ((use_ra && pending(ra)) || (use_rb && pending(rb)) ||
                                     (use_rd && pending(rd)));
   assign issue  = fetch_i.valid && !halted_q && !hazard && mem_ready_i;

   // after halt the fetch register is drained without issuing
   assign decode_ready_o = halted_q || (mem_ready_i && !hazard);

   always_ff @(posedge clk_i) begin
      if (wb_i.valid && wb_i.rd != '0) begin
         regs[wb_i.rd] <= wb_i.data;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         exec_q.valid <= 1'b0;
         halted_q     <= 1'b0;
      end else if (mem_ready_i) begin
         exec_q.valid      <= issue;
         exec_q.op         <= op;
         exec_q.rd         <= rd;
         exec_q.a          <= read_reg(ra);
         exec_q.b          <= read_reg(use_rd ? rd : rb);
         exec_q.imm        <= imm;
         exec_q.writes_reg <= writes;
         if (issue && op == op_halt) begin
            halted_q <= 1'b1;
         end
      end
   end

   assign exec_o       = exec_q;
   assign fetch_stop_o = halted_q;

endmodule

`default_nettype wire

// ==== verilog/ifetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifetch (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  logic                     ins_ack_i,
   input  cpu_isa_pkg::word_t       ins_dat_i,
   output logic                     ins_cyc_o,
   output cpu_isa_pkg::word_t       ins_adr_o,
   input  logic                     decode_ready_i,
   input  logic                     fetch_stop_i,
   output cpu_pipe_pkg::fetch_pkt_t fetch_o
);

   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   word_t      pc_q;
   logic       cyc_q;
   fetch_pkt_t fetch_q;
   logic       start;
   logic       acked;

   // only one cycle is open at a time, and the fetch register is empty when it ends
   assign start = !cyc_q && !fetch_stop_i && (!fetch_q.valid || decode_ready_i);
   assign acked = cyc_q && ins_ack_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         pc_q          <= reset_pc_c;
         cyc_q         <= 1'b0;
         fetch_q.valid <= 1'b0;
      end else begin
         if (decode_ready_i) begin
            fetch_q.valid <= 1'b0;
         end
         if (start) begin
            cyc_q <= 1'b1;
         end
         if (acked) begin
            cyc_q         <= 1'b0;
            pc_q          <= pc_q + 32'd4;
            // words that arrive after halt are thrown away
            fetch_q.valid <= !fetch_stop_i;
            fetch_q.pc    <= pc_q;
            fetch_q.ins   <= ins_dat_i;
         end
      end
   end

   assign ins_cyc_o = cyc_q;
   assign ins_adr_o = pc_q;
   assign fetch_o   = fetch_q;

endmodule

`default_nettype wire

// ==== verilog/mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem (
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  cpu_pipe_pkg::mem_pkt_t mem_i,
   output logic                   mem_ready_o,
   input  logic                   dat_ack_i,
   input  cpu_isa_pkg::word_t     dat_dat_i,
   output logic                   dat_cyc_o,
   output logic                   dat_we_o,
   output cpu_isa_pkg::word_t     dat_adr_o,
   output cpu_isa_pkg::word_t     dat_dat_o,
   output cpu_pipe_pkg::wb_pkt_t  wb_o,
   output logic                   halt_o
);

   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;

   wb_pkt_t wb_q;
   logic    cyc_q;
   logic    we_q;
   logic    halt_q;
   logic    is_ld;
   logic    is_st;
   logic    acked;

   assign is_ld = mem_i.valid && mem_i.op == op_ld;
   assign is_st = mem_i.valid && mem_i.op == op_st;
   assign acked = cyc_q && dat_ack_i;

   // the pipe holds until the access is acknowledged
   assign mem_ready_o = !(is_ld || is_st) || acked;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cyc_q      <= 1'b0;
         we_q       <= 1'b0;
         halt_q     <= 1'b0;
         wb_q.valid <= 1'b0;
      end else begin
         if ((is_ld || is_st) && !cyc_q) begin
            cyc_q <= 1'b1;
            we_q  <= is_st;
         end else if (acked) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
         end
         if (mem_i.valid && mem_i.op == op_halt) begin
            halt_q <= 1'b1;
         end
         wb_q.valid <= mem_i.valid && mem_i.writes_reg && (!is_ld || acked);
         wb_q.rd    <= mem_i.rd;
         wb_q.data  <= is_ld ? dat_dat_i : mem_i.result;
      end
   end

   // address and data come straight from the held packet
   assign dat_cyc_o = cyc_q;
   assign dat_we_o  = we_q;
   assign dat_adr_o = mem_i.result;
   assign dat_dat_o = mem_i.store_data;
   assign wb_o      = wb_q;
   assign halt_o    = halt_q;

endmodule

`default_nettype wire
